/* fpu_pkg.sv */
package fpu_pkg;

    typedef logic [31:0] fp_word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [7:0]  exp_t;

    // significand including the hidden bit.
    typedef logic [23:0] mant_t;

    // tells the result pipe where the write-back value comes from.
    typedef logic [1:0]  wb_src_t;

    localparam logic [6:0] OPC_OP_FP    = 7'b1010011;
    localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
    localparam logic [6:0] OPC_STORE_FP = 7'b0100111;

    // fmt field of funct7 for single precision, and funct3 of flw/fsw.
    localparam logic [1:0] FMT_S = 2'b00;
    localparam logic [2:0] F3_W  = 3'b010;

    localparam logic [4:0] F5_ADD    = 5'b00000;
    localparam logic [4:0] F5_SUB    = 5'b00001;
    localparam logic [4:0] F5_MUL    = 5'b00010;
    localparam logic [4:0] F5_MV_X_W = 5'b11100;
    localparam logic [4:0] F5_MV_W_X = 5'b11110;

    localparam wb_src_t SRC_LOAD = 2'd0;
    localparam wb_src_t SRC_MOVE = 2'd1;
    localparam wb_src_t SRC_ADD  = 2'd2;
    localparam wb_src_t SRC_MUL  = 2'd3;

    // cycles from issue to result for each unit, and issue to register write.
    localparam int ADDSUB_LAT = 2;
    localparam int MUL_LAT    = 4;
    localparam int WB_LAT     = 5;

    localparam int EXP_BIAS = 127;

endpackage

/* fpu_issue_if.sv */
interface fpu_issue_if import fpu_pkg::*; ();

    fp_word_t op_a;
    fp_word_t op_b;
    logic     add_go;
    logic     mul_go;
    logic     is_sub;

    modport decoder (
        output op_a, op_b, add_go, mul_go, is_sub
    );

    modport addsub (
        input op_a, op_b, add_go, is_sub
    );

    modport mul (
        input op_a, op_b, mul_go
    );

endinterface

/* fp_regfile.sv */
module fp_regfile import fpu_pkg::*; (
    input  logic     clk,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    output fp_word_t rd1,
    output fp_word_t rd2,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  fp_word_t wr_data
);

    // f0 is a normal storage register, unlike x0 in the integer file.
    fp_word_t regs [0:(1 << $bits(reg_idx_t)) - 1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rd1 = regs[rs1_idx];
    assign rd2 = regs[rs2_idx];

endmodule

/* fpu_decode.sv */
module fpu_decode import fpu_pkg::*; (
    input  logic        [31:0] inst,
    input  logic               inst_valid,
    input  fp_word_t           from_intreg,
    input  fp_word_t           from_mem,
    input  fp_word_t           rd1,
    input  fp_word_t           rd2,
    output reg_idx_t           rs1_idx,
    output reg_idx_t           rs2_idx,
    output logic               wb_en,
    output reg_idx_t           wb_rd,
    output wb_src_t            wb_src,
    output fp_word_t           imm_data,
    fpu_issue_if.decoder       issue
);

    logic [6:0] opcode;
    logic [4:0] funct5;
    logic [1:0] fmt;
    logic [2:0] funct3;

    logic add_op;
    logic sub_op;
    logic mul_op;
    logic wr_op;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign fmt    = inst[26:25];
    assign funct5 = inst[31:27];

    assign rs1_idx = inst[19:15];
    assign rs2_idx = inst[24:20];
    assign wb_rd   = inst[11:7];

    always_comb begin
        add_op = 1'b0;
        sub_op = 1'b0;
        mul_op = 1'b0;
        wr_op  = 1'b0;
        wb_src = SRC_MOVE;
        case (opcode)
            OPC_LOAD_FP: begin
                if (funct3 == F3_W) begin
                    wr_op  = 1'b1;
                    wb_src = SRC_LOAD;
                end
            end
            OPC_STORE_FP: begin
                // fsw only reads rs2, which leaves the unit on to_mem.
                wr_op = 1'b0;
            end
            OPC_OP_FP: begin
                if (fmt == FMT_S) begin
                    case (funct5)
                        F5_ADD: begin
                            add_op = 1'b1;
                            wr_op  = 1'b1;
                            wb_src = SRC_ADD;
                        end
                        F5_SUB: begin
                            add_op = 1'b1;
                            sub_op = 1'b1;
                            wr_op  = 1'b1;
                            wb_src = SRC_ADD;
                        end
                        F5_MUL: begin
                            mul_op = 1'b1;
                            wr_op  = 1'b1;
                            wb_src = SRC_MUL;
                        end
                        F5_MV_W_X: begin
                            wr_op  = 1'b1;
                            wb_src = SRC_MOVE;
                        end
                        F5_MV_X_W: begin
                            // the rs1 read port goes straight out on to_intreg.
                            wr_op = 1'b0;
                        end
                        default: begin
                            wr_op = 1'b0;
                        end
                    endcase
                end
            end
            default: begin
                wr_op = 1'b0;
            end
        endcase
    end

    assign wb_en    = inst_valid && wr_op;
    assign imm_data = (wb_src == SRC_LOAD) ? from_mem : from_intreg;

    assign issue.op_a   = rd1;
    assign issue.op_b   = rd2;
    assign issue.add_go = inst_valid && add_op;
    assign issue.mul_go = inst_valid && mul_op;
    assign issue.is_sub = sub_op;

endmodule

/* fp_addsub.sv */
module fp_addsub import fpu_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    fpu_issue_if.addsub issue,
    output fp_word_t    sum
);

    logic  a_sign;
    logic  b_sign;
    exp_t  a_exp;
    exp_t  b_exp;
    mant_t a_mant;
    mant_t b_mant;
    logic  a_larger;
    exp_t  exp_diff;

    logic  s1_valid;
    logic  s1_sign;
    logic  s1_sub;
    exp_t  s1_exp;
    mant_t s1_big;
    mant_t s1_small;

    logic        [24:0] mag;
    logic        [4:0]  lz;
    mant_t              norm_mant;
    logic signed [9:0]  norm_exp;
    fp_word_t           result;

    function automatic logic [4:0] lzc24(input logic [23:0] v);
        logic [4:0] n;
        n = 5'd24;
        for (int i = 0; i < 24; i++) begin
            if (v[i]) begin
                n = 5'(23 - i);
            end
        end
        return n;
    endfunction

    assign a_sign = issue.op_a[31];
    assign b_sign = issue.op_b[31] ^ issue.is_sub;
    assign a_exp  = issue.op_a[30:23];
    assign b_exp  = issue.op_b[30:23];

    // a zero exponent means zero or denormal, both flushed here.
    assign a_mant = (a_exp == '0) ? '0 : {1'b1, issue.op_a[22:0]};
    assign b_mant = (b_exp == '0) ? '0 : {1'b1, issue.op_b[22:0]};

    assign a_larger = issue.op_a[30:0] >= issue.op_b[30:0];
    assign exp_diff = a_larger ? a_exp - b_exp : b_exp - a_exp;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue.add_go;
        end
    end

    // bits shifted out of the smaller significand are simply lost.
    always_ff @(posedge clk) begin
        if (issue.add_go) begin
            s1_sign  <= a_larger ? a_sign : b_sign;
            s1_sub   <= a_sign ^ b_sign;
            s1_exp   <= a_larger ? a_exp : b_exp;
            s1_big   <= a_larger ? a_mant : b_mant;
            s1_small <= (a_larger ? b_mant : a_mant) >> exp_diff;
        end
    end

    // the swap guarantees big >= small, so the difference never goes negative.
    assign mag = s1_sub ? {1'b0, s1_big} - {1'b0, s1_small}
                        : {1'b0, s1_big} + {1'b0, s1_small};
    assign lz  = lzc24(mag[23:0]);

    always_comb begin
        if (mag[24]) begin
            norm_mant = mag[24:1];
            norm_exp  = 10'(s1_exp) + 10'sd1;
        end else begin
            norm_mant = mag[23:0] << lz;
            norm_exp  = 10'(s1_exp) - 10'(lz);
        end
    end

    always_comb begin
        if (mag == '0) begin
            result = '0;
        end else if (norm_exp <= 10'sd0) begin
            result = {s1_sign, 31'b0};
        end else if (norm_exp > 2 * EXP_BIAS) begin
            result = {s1_sign, 8'hff, 23'b0};
        end else begin
            result = {s1_sign, norm_exp[7:0], norm_mant[22:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            sum <= result;
        end
    end

endmodule

/* fp_mul.sv */
module fp_mul import fpu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    fpu_issue_if.mul issue,
    output fp_word_t product
);

    exp_t              a_exp;
    exp_t              b_exp;
    logic signed [9:0] exp_sum;

    logic [1:MUL_LAT-1] valid;

    logic              s1_sign;
    logic              s1_zero;
    logic signed [9:0] s1_exp;
    mant_t             s1_a;
    mant_t             s1_b;

    logic              s2_sign;
    logic              s2_zero;
    logic signed [9:0] s2_exp;
    logic [35:0]       s2_lo;
    logic [35:0]       s2_hi;

    logic              s3_sign;
    logic              s3_zero;
    logic signed [9:0] s3_exp;
    logic [47:0]       s3_prod;

    mant_t             norm_mant;
    logic signed [9:0] norm_exp;
    fp_word_t          result;

    assign a_exp   = issue.op_a[30:23];
    assign b_exp   = issue.op_b[30:23];
    assign exp_sum = 10'(a_exp) + 10'(b_exp) - 10'(EXP_BIAS);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
        end else begin
            valid <= {issue.mul_go, valid[1:MUL_LAT-2]};
        end
    end

    always_ff @(posedge clk) begin
        if (issue.mul_go) begin
            s1_sign <= issue.op_a[31] ^ issue.op_b[31];
            s1_zero <= (a_exp == '0) || (b_exp == '0);
            s1_exp  <= exp_sum;
            s1_a    <= {1'b1, issue.op_a[22:0]};
            s1_b    <= {1'b1, issue.op_b[22:0]};
        end
        // two 24x12 partial products, then one wide add.
        if (valid[1]) begin
            s2_sign <= s1_sign;
            s2_zero <= s1_zero;
            s2_exp  <= s1_exp;
            s2_lo   <= s1_a * s1_b[11:0];
            s2_hi   <= s1_a * s1_b[23:12];
        end
        if (valid[2]) begin
            s3_sign <= s2_sign;
            s3_zero <= s2_zero;
            s3_exp  <= s2_exp;
            s3_prod <= {s2_hi, 12'b0} + {12'b0, s2_lo};
        end
        if (valid[3]) begin
            product <= result;
        end
    end

    // the product of two values in [1,2) needs at most a one bit shift.
    always_comb begin
        if (s3_prod[47]) begin
            norm_mant = s3_prod[47:24];
            norm_exp  = s3_exp + 10'sd1;
        end else begin
            norm_mant = s3_prod[46:23];
            norm_exp  = s3_exp;
        end
        if (s3_zero || norm_exp <= 10'sd0) begin
            result = {s3_sign, 31'b0};
        end else if (norm_exp > 2 * EXP_BIAS) begin
            result = {s3_sign, 8'hff, 23'b0};
        end else begin
            result = {s3_sign, norm_exp[7:0], norm_mant[22:0]};
        end
    end

endmodule

/* fpu_result_pipe.sv */
module fpu_result_pipe import fpu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     wb_en,
    input  reg_idx_t wb_rd,
    input  wb_src_t  wb_src,
    input  fp_word_t imm_data,
    input  fp_word_t sum,
    input  fp_word_t product,
    output logic     wr_en,
    output reg_idx_t wr_idx,
    output fp_word_t wr_data
);

    logic [1:WB_LAT] en_q;
    reg_idx_t        rd_q   [1:WB_LAT];
    wb_src_t         src_q  [1:WB_LAT-1];
    fp_word_t        data_q [1:WB_LAT];
    fp_word_t        data_d [2:WB_LAT];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            en_q <= '0;
        end else begin
            en_q <= {wb_en, en_q[1:WB_LAT-1]};
        end
    end

    // a unit's result is picked up in the stage right after its latency.
    always_comb begin
        for (int k = 2; k <= WB_LAT; k++) begin
            if (k == ADDSUB_LAT + 1 && src_q[k-1] == SRC_ADD) begin
                data_d[k] = sum;
            end else if (k == MUL_LAT + 1 && src_q[k-1] == SRC_MUL) begin
                data_d[k] = product;
            end else begin
                data_d[k] = data_q[k-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_q[1]   <= wb_rd;
        src_q[1]  <= wb_src;
        data_q[1] <= imm_data;
        for (int k = 2; k <= WB_LAT; k++) begin
            rd_q[k]   <= rd_q[k-1];
            data_q[k] <= data_d[k];
        end
        for (int k = 2; k < WB_LAT; k++) begin
            src_q[k] <= src_q[k-1];
        end
    end

    assign wr_en   = en_q[WB_LAT];
    assign wr_idx  = rd_q[WB_LAT];
    assign wr_data = data_q[WB_LAT];

endmodule

/* fpu.sv */
module fpu import fpu_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [31:0] inst,
    input  logic        inst_valid,
    input  fp_word_t    from_intreg,
    input  fp_word_t    from_mem,
    output fp_word_t    to_mem,
    output fp_word_t    to_intreg
);

    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    logic     wb_en;
    reg_idx_t wb_rd;
    wb_src_t  wb_src;
    fp_word_t imm_data;
    fp_word_t sum;
    fp_word_t product;
    logic     wr_en;
    reg_idx_t wr_idx;
    fp_word_t wr_data;

    fpu_issue_if issue_bus ();

    // the rs1 and rs2 read ports double as the fmv.x.w and fsw outputs.
    fpu_decode u_decode (
        .inst        (inst),
        .inst_valid  (inst_valid),
        .from_intreg (from_intreg),
        .from_mem    (from_mem),
        .rd1         (to_intreg),
        .rd2         (to_mem),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_src      (wb_src),
        .imm_data    (imm_data),
        .issue       (issue_bus.decoder)
    );

    fp_regfile u_regfile (
        .clk     (clk),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rd1     (to_intreg),
        .rd2     (to_mem),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data)
    );

    fp_addsub u_addsub (
        .clk    (clk),
        .arst_n (arst_n),
        .issue  (issue_bus.addsub),
        .sum    (sum)
    );

    fp_mul u_mul (
        .clk     (clk),
        .arst_n  (arst_n),
        .issue   (issue_bus.mul),
        .product (product)
    );

    fpu_result_pipe u_result_pipe (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_src   (wb_src),
        .imm_data (imm_data),
        .sum      (sum),
        .product  (product),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data)
    );

endmodule

/* fpu_checker.sv */
module fpu_checker import fpu_pkg::*; (
    input logic clk,
    input logic arst_n,
    input logic wb_en,
    input logic wr_en,
    input logic add_go,
    input logic mul_go
);

    // counts edges since reset was released and holds at the write-back latency.
    logic [3:0] cycles;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cycles <= '0;
        end else if (cycles < 4'(WB_LAT)) begin
            cycles <= cycles + 4'd1;
        end
    end

    no_early_write: assert property (
        @(posedge clk) disable iff (!arst_n)
        (cycles < 4'(WB_LAT)) |-> !wr_en
    ) else $error("register write seen within the first cycles after reset");

    write_follows_issue: assert property (
        @(posedge clk) disable iff (!arst_n)
        (cycles >= 4'(WB_LAT)) |-> (wr_en == $past(wb_en, WB_LAT))
    ) else $error("register write does not match the write enable of five cycles earlier");

    one_unit_per_issue: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(add_go && mul_go)
    ) else $error("adder and multiplier started in the same cycle");

endmodule

// the top level sees the write-back enables and the issue bus in one scope.
bind fpu fpu_checker u_checker (
    .clk    (clk),
    .arst_n (arst_n),
    .wb_en  (wb_en),
    .wr_en  (wr_en),
    .add_go (issue_bus.add_go),
    .mul_go (issue_bus.mul_go)
);

/* tb_fpu.sv */
module tb_fpu import fpu_pkg::*; ();

    localparam int WATCHDOG_CYCLES = 2000;

    logic        clk;
    logic        arst_n;
    logic [31:0] inst;
    logic        inst_valid;
    fp_word_t    from_intreg;
    fp_word_t    from_mem;
    fp_word_t    to_mem;
    fp_word_t    to_intreg;

    integer seed;
    int     errors;

    fpu uut (
        .clk         (clk),
        .arst_n      (arst_n),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .from_intreg (from_intreg),
        .from_mem    (from_mem),
        .to_mem      (to_mem),
        .to_intreg   (to_intreg)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] fp_op(input logic [4:0] f5, input reg_idx_t rd,
                                          input reg_idx_t rs1, input reg_idx_t rs2);
        logic [2:0] rm;
        // moves use funct3 000, arithmetic asks for round toward zero.
        rm = (f5 == F5_MV_X_W || f5 == F5_MV_W_X) ? 3'b000 : 3'b001;
        return {f5, FMT_S, rs2, rs1, rm, rd, OPC_OP_FP};
    endfunction

    function automatic logic [31:0] flw_inst(input reg_idx_t rd);
        return {12'd0, 5'd0, F3_W, rd, OPC_LOAD_FP};
    endfunction

    function automatic logic [31:0] fsw_inst(input reg_idx_t rs2);
        return {7'd0, rs2, 5'd0, F3_W, 5'd0, OPC_STORE_FP};
    endfunction

    // exact conversion, valid for magnitudes below 2**24.
    function automatic fp_word_t int_to_fp(input int v);
        logic [31:0] mag;
        logic [31:0] shifted;
        int          msb;
        if (v == 0) begin
            return '0;
        end
        mag = (v < 0) ? -v : v;
        msb = 0;
        for (int i = 0; i < 24; i++) begin
            if (mag[i]) begin
                msb = i;
            end
        end
        shifted = mag << (23 - msb);
        return {v < 0, 8'(EXP_BIAS + msb), shifted[22:0]};
    endfunction

    task automatic check(input string name, input fp_word_t got, input fp_word_t expected);
        if (got !== expected) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, expected);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic drive(input logic [31:0] word, input logic valid,
                         input fp_word_t int_val, input fp_word_t mem_val);
        @(posedge clk);
        inst        <= word;
        inst_valid  <= valid;
        from_intreg <= int_val;
        from_mem    <= mem_val;
    endtask

    task automatic idle(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(posedge clk);
            inst_valid <= 1'b0;
        end
    endtask

    task automatic write_reg(input reg_idx_t rd, input fp_word_t value);
        drive(fp_op(F5_MV_W_X, rd, 5'd0, 5'd0), 1'b1, value, '0);
        idle(WB_LAT);
    endtask

    task automatic run_op(input logic [4:0] f5, input reg_idx_t rd,
                          input reg_idx_t rs1, input reg_idx_t rs2);
        drive(fp_op(f5, rd, rs1, rs2), 1'b1, '0, '0);
        idle(WB_LAT);
    endtask

    task automatic read_reg(input reg_idx_t rs, input string name, input fp_word_t expected);
        drive(fp_op(F5_MV_X_W, 5'd0, rs, 5'd0), 1'b1, '0, '0);
        @(negedge clk);
        check(name, to_intreg, expected);
    endtask

    task automatic store_check(input reg_idx_t rs2, input fp_word_t expected);
        drive(fsw_inst(rs2), 1'b1, '0, '0);
        @(negedge clk);
        check("to_mem", to_mem, expected);
    endtask

    task automatic test_moves();
        reg_idx_t rd;
        fp_word_t value;
        for (int n = 0; n < 8; n++) begin
            rd    = reg_idx_t'($random(seed));
            value = $random(seed);
            write_reg(rd, value);
            read_reg(rd, "to_intreg", value);
            store_check(rd, value);
        end
    endtask

    task automatic test_load();
        fp_word_t value;
        for (int n = 0; n < 2; n++) begin
            value = $random(seed);
            drive(flw_inst(reg_idx_t'(21 + n)), 1'b1, '0, value);
            idle(WB_LAT);
            store_check(reg_idx_t'(21 + n), value);
        end
    endtask

    task automatic test_addsub();
        int a;
        int b;
        write_reg(5'd1, 32'h3fc00000);
        write_reg(5'd2, 32'h40100000);
        write_reg(5'd4, 32'h3f800000);
        write_reg(5'd5, 32'h40400000);
        // 2**-24 lies a full significand below 1.0 and is lost in alignment.
        write_reg(5'd6, 32'h33800000);
        run_op(F5_ADD, 5'd3, 5'd1, 5'd2);
        read_reg(5'd3, "fadd 1.5+2.25", 32'h40700000);
        run_op(F5_SUB, 5'd7, 5'd4, 5'd5);
        read_reg(5'd7, "fsub 1.0-3.0", 32'hc0000000);
        run_op(F5_SUB, 5'd8, 5'd1, 5'd1);
        read_reg(5'd8, "fsub x-x", 32'h00000000);
        run_op(F5_ADD, 5'd9, 5'd4, 5'd6);
        read_reg(5'd9, "fadd truncation", 32'h3f800000);
        for (int n = 0; n < 4; n++) begin
            a = ($random(seed) & 32'hffff) + 1;
            b = ($random(seed) & 32'hffff) + 1;
            write_reg(5'd10, int_to_fp(a));
            write_reg(5'd11, int_to_fp(b));
            run_op(F5_ADD, 5'd12, 5'd10, 5'd11);
            read_reg(5'd12, "fadd random", int_to_fp(a + b));
            run_op(F5_SUB, 5'd13, 5'd10, 5'd11);
            read_reg(5'd13, "fsub random", int_to_fp(a - b));
        end
    endtask

    // f1 still holds 1.5 from the add and subtract test.
    task automatic test_mul();
        int a;
        int b;
        write_reg(5'd14, 32'h40000000);
        write_reg(5'd15, 32'hbf000000);
        write_reg(5'd16, 32'h40c00000);
        write_reg(5'd17, 32'h00000000);
        write_reg(5'd18, 32'h71800000);
        run_op(F5_MUL, 5'd19, 5'd1, 5'd14);
        read_reg(5'd19, "fmul 1.5*2.0", 32'h40400000);
        run_op(F5_MUL, 5'd19, 5'd15, 5'd16);
        read_reg(5'd19, "fmul -0.5*6.0", 32'hc0400000);
        run_op(F5_MUL, 5'd19, 5'd15, 5'd17);
        read_reg(5'd19, "fmul -0.5*0", 32'h80000000);
        run_op(F5_MUL, 5'd19, 5'd18, 5'd18);
        read_reg(5'd19, "fmul overflow", 32'h7f800000);
        for (int n = 0; n < 4; n++) begin
            a = ($random(seed) & 32'h7ff) + 1;
            b = ($random(seed) & 32'h7ff) + 1;
            if ($random(seed) & 1) begin
                a = -a;
            end
            write_reg(5'd10, int_to_fp(a));
            write_reg(5'd11, int_to_fp(b));
            run_op(F5_MUL, 5'd12, 5'd10, 5'd11);
            read_reg(5'd12, "fmul random", int_to_fp(a * b));
        end
    endtask

    // three results share the write port on consecutive cycles.
    task automatic test_back_to_back();
        drive(fp_op(F5_MUL, 5'd24, 5'd1, 5'd14), 1'b1, '0, '0);
        drive(fp_op(F5_ADD, 5'd25, 5'd1, 5'd2), 1'b1, '0, '0);
        drive(flw_inst(5'd26), 1'b1, '0, 32'h40490fdb);
        idle(WB_LAT);
        read_reg(5'd24, "back-to-back fmul", 32'h40400000);
        read_reg(5'd25, "back-to-back fadd", 32'h40700000);
        read_reg(5'd26, "back-to-back flw", 32'h40490fdb);
    endtask

    task automatic test_no_write();
        write_reg(5'd20, 32'h12345678);
        drive(fp_op(F5_MV_W_X, 5'd20, 5'd0, 5'd0), 1'b0, 32'hdeadbeef, '0);
        drive(fsw_inst(5'd3) | (32'd20 << 7), 1'b1, 32'hdeadbeef, 32'hdeadbeef);
        drive(fp_op(F5_MV_X_W, 5'd20, 5'd3, 5'd0), 1'b1, 32'hdeadbeef, 32'hdeadbeef);
        idle(WB_LAT);
        read_reg(5'd20, "f20 after non-writing cycles", 32'h12345678);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the test sequence did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $fatal(1);
    end

    initial begin
        seed        = 32'hab17dae8;
        errors      = 0;
        clk         = 1'b0;
        arst_n      = 1'b0;
        inst        = '0;
        inst_valid  = 1'b0;
        from_intreg = '0;
        from_mem    = '0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        test_moves();
        test_load();
        test_addsub();
        test_mul();
        test_back_to_back();
        test_no_write();
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* fpu.f */
fpu_pkg.sv
fpu_issue_if.sv
fp_regfile.sv
fpu_decode.sv
fp_addsub.sv
fp_mul.sv
fpu_result_pipe.sv
fpu.sv
fpu_checker.sv
tb_fpu.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f fpu.f --top-module tb_fpu

./obj_dir/Vtb_fpu 2>&1 | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    echo "run.sh: test run passed"
else
    echo "run.sh: test run failed, see sim.log"
    exit 1
fi
